//--- Makefile
# Verilator build and run for the memory wrapper testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tbCapMem
FILELIST  ?= src.f
OBJDIR    ?= obj_dir

SIM := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# A failing run exits non-zero through $$fatal
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

//--- capAccessDecode.sv
// Request decode for the memory wrapper: datapath strobes with strict
// priority, a pending CPU slot and the CPU busy tracking

`timescale 1ns/100ps

module capAccessDecode #(
   parameter int readStages = 2
) (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         dpRd,
   input  logic                         dpWr,
   input  logic [capMemPkg::addrW-1:0]  dpAddr,
   input  logic [capMemPkg::dataW-1:0]  dpWrData,
   input  logic                         cpuReq,
   input  logic                         cpuWrite,
   input  logic [capMemPkg::addrW-1:0]  cpuAddr,
   input  logic [capMemPkg::dataW-1:0]  cpuWrData,
   output capMemPkg::memReqT            issue,
   output logic                         cpuBusy
);

   import capMemPkg::*;

   // Counts grant to ack, 1+readStages cycles
   localparam int cntW = $clog2(readStages + 2);

   memReqT          cpuIn;
   memReqT          pendReq;
   memReqT          cpuOp;
   logic            dpIdle;
   logic            cpuGrant;
   logic [cntW-1:0] cntQ;
   logic            busyQ;

   ////////////////////
   // CPU candidate
   ////////////////////

   // Incoming CPU request as an array operation
   always_comb begin
      cpuIn.valid  = cpuReq;
      cpuIn.write  = cpuWrite;
      cpuIn.owner  = ownerCpu;
      cpuIn.addr   = cpuAddr;
      cpuIn.wrData = cpuWrData;
   end

   // A held request wins over the input, which is idle then anyway
   assign cpuOp    = pendReq.valid ? pendReq : cpuIn;
   assign dpIdle   = !dpRd && !dpWr;
   // CPU only gets cycles with no datapath strobe
   assign cpuGrant = dpIdle && cpuOp.valid;

   ////////////////////
   // Issue
   ////////////////////

   always_comb begin
      issue = '0;
      if (!dpIdle) begin
         issue.valid  = 1'b1;
         issue.write  = dpWr;
         issue.owner  = ownerDp;
         issue.addr   = dpAddr;
         issue.wrData = dpWrData;
      end else if (cpuGrant) begin
         issue = cpuOp;
      end
   end

   ////////////////////
   // Pending slot
   ////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pendReq <= '0;
      end else if (cpuReq && !dpIdle) begin
         // Datapath busy this cycle, hold the request
         pendReq <= cpuIn;
      end else if (cpuGrant) begin
         pendReq.valid <= 1'b0;
      end
   end

   ////////////////////
   // Busy and ack countdown
   ////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         cntQ  <= '0;
         busyQ <= 1'b0;
      end else begin
         if (cpuGrant) begin
            cntQ <= cntW'(readStages + 1);
         end else if (cntQ != '0) begin
            cntQ <= cntQ - 1'b1;
         end
         // Set from the cycle after the pulse
         if (cpuReq) begin
            busyQ <= 1'b1;
         end else if (cntQ == cntW'(1)) begin
            // Last count is the ack cycle, drop afterwards
            busyQ <= 1'b0;
         end
      end
   end

   assign cpuBusy = busyQ;

   // Datapath is a single strobe per cycle
   assert property (@(posedge clk) disable iff (!rstN) !(dpRd && dpWr));

   // Only one CPU operation in flight
   assert property (@(posedge clk) disable iff (!rstN) cpuReq |-> !cpuBusy);

endmodule

//--- capMemArray.sv
// Single-port storage array with write on the issue edge and a
// registered, owner-tagged read result

`timescale 1ns/100ps

module capMemArray (
   input  logic                  clk,
   input  logic                  rstN,
   input  capMemPkg::memReqT     issue,
   output capMemPkg::arrayRespT  arrayResp
);

   import capMemPkg::*;

   localparam int depth = 1 << addrW;

   logic [dataW-1:0] memQ [depth];
   arrayRespT        respQ;

   ////////////////////
   // Storage
   ////////////////////

   // Contents are undefined until written
   always_ff @(posedge clk) begin
      if (issue.valid && issue.write) begin
         memQ[issue.addr] <= issue.wrData;
      end
   end

   ////////////////////
   // Result register
   ////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         respQ <= '0;
      end else begin
         respQ.valid <= issue.valid;
         if (issue.valid) begin
            respQ.owner   <= issue.owner;
            respQ.isWrite <= issue.write;
            // Old word on a write, which nobody consumes
            respQ.rdData  <= memQ[issue.addr];
         end
      end
   end

   assign arrayResp = respQ;

   // One result per request, exactly one cycle later
   assert property (@(posedge clk) disable iff (!rstN)
      arrayResp.valid == $past(issue.valid));

endmodule

//--- capMemPkg.sv
// Shared widths, requester encoding and the request and response
// structs of the latency-configurable memory wrapper

package capMemPkg;

   ////////////////////
   // Widths
   ////////////////////

   // 256-entry array
   localparam int addrW = 8;
   // One word per entry
   localparam int dataW = 32;

   ////////////////////
   // Requester
   ////////////////////

   // Tags every request and result with its source
   typedef enum logic {
      ownerDp  = 1'b0,
      ownerCpu = 1'b1
   } ownerT;

   ////////////////////
   // Array side
   ////////////////////

   // One operation into the array, at most one per cycle
   typedef struct packed {
      logic             valid;
      logic             write;
      ownerT            owner;
      logic [addrW-1:0] addr;
      logic [dataW-1:0] wrData;
   } memReqT;

   // Registered array result, one cycle after the request
   typedef struct packed {
      logic             valid;
      ownerT            owner;
      logic             isWrite;
      logic [dataW-1:0] rdData;
   } arrayRespT;

   ////////////////////
   // Requester side
   ////////////////////

   // Datapath read return, reads only
   typedef struct packed {
      logic             valid;
      logic [dataW-1:0] data;
   } dpRespT;

   // CPU completion for reads and writes alike
   typedef struct packed {
      logic             ack;
      logic [dataW-1:0] rdData;
   } cpuRespT;

endpackage

//--- capMemTop.sv
// Top level of the memory wrapper: decode, array and result route
// wired together, responses unpacked onto flat ports

`timescale 1ns/100ps

module capMemTop #(
   parameter int readStages = 2
) (
   input  logic                         clk,
   input  logic                         rstN,
   // Datapath
   input  logic                         dpRd,
   input  logic                         dpWr,
   input  logic [capMemPkg::addrW-1:0]  dpAddr,
   input  logic [capMemPkg::dataW-1:0]  dpWrData,
   output logic                         dpRdValid,
   output logic [capMemPkg::dataW-1:0]  dpRdData,
   // CPU register access
   input  logic                         cpuReq,
   input  logic                         cpuWrite,
   input  logic [capMemPkg::addrW-1:0]  cpuAddr,
   input  logic [capMemPkg::dataW-1:0]  cpuWrData,
   output logic                         cpuBusy,
   output logic                         cpuAck,
   output logic [capMemPkg::dataW-1:0]  cpuRdData
);

   import capMemPkg::*;

   memReqT    issue;
   arrayRespT arrayResp;
   dpRespT    dpResp;
   cpuRespT   cpuResp;

   capAccessDecode #(.readStages(readStages)) decode (
      .clk(clk), .rstN(rstN),
      .dpRd(dpRd), .dpWr(dpWr), .dpAddr(dpAddr), .dpWrData(dpWrData),
      .cpuReq(cpuReq), .cpuWrite(cpuWrite), .cpuAddr(cpuAddr),
      .cpuWrData(cpuWrData), .issue(issue), .cpuBusy(cpuBusy)
   );

   capMemArray memArray (
      .clk(clk), .rstN(rstN), .issue(issue), .arrayResp(arrayResp)
   );

   capRespRoute #(.readStages(readStages)) respRoute (
      .clk(clk), .rstN(rstN), .arrayResp(arrayResp),
      .dpResp(dpResp), .cpuResp(cpuResp)
   );

   // Flat outputs
   assign dpRdValid = dpResp.valid;
   assign dpRdData  = dpResp.data;
   assign cpuAck    = cpuResp.ack;
   assign cpuRdData = cpuResp.rdData;

endmodule

//--- capRespRoute.sv
// Result routing: splits array results by owner and delays each side
// through its own pipe into datapath and CPU responses

`timescale 1ns/100ps

module capRespRoute #(
   parameter int readStages = 2
) (
   input  logic                  clk,
   input  logic                  rstN,
   input  capMemPkg::arrayRespT  arrayResp,
   output capMemPkg::dpRespT     dpResp,
   output capMemPkg::cpuRespT    cpuResp
);

   import capMemPkg::*;

   dpRespT  dpIn;
   cpuRespT cpuIn;

   ////////////////////
   // Steering
   ////////////////////

   always_comb begin
      // Datapath writes return nothing
      dpIn.valid = arrayResp.valid && (arrayResp.owner == ownerDp)
                   && !arrayResp.isWrite;
      dpIn.data  = arrayResp.rdData;
   end

   always_comb begin
      // CPU reads and writes both complete with an ack
      cpuIn.ack    = arrayResp.valid && (arrayResp.owner == ownerCpu);
      cpuIn.rdData = arrayResp.rdData;
   end

   ////////////////////
   // Latency
   ////////////////////

   // Same depth on both sides keeps the ack timing in step with decode
   capSyncPipe #(
      .readStages (readStages),
      .payloadT   (dpRespT)
   ) dpPipe (
      .clk     (clk),
      .rstN    (rstN),
      .dataIn  (dpIn),
      .dataOut (dpResp)
   );

   capSyncPipe #(
      .readStages (readStages),
      .payloadT   (cpuRespT)
   ) cpuPipe (
      .clk     (clk),
      .rstN    (rstN),
      .dataIn  (cpuIn),
      .dataOut (cpuResp)
   );

   // One owner per array slot, so the two pipe outputs never collide
   assert property (@(posedge clk) disable iff (!rstN)
      !(dpResp.valid && cpuResp.ack));

endmodule

//--- capSyncPipe.sv
// Delay line of readStages registers for an arbitrary payload type,
// a plain wire when readStages is 0

`timescale 1ns/100ps

module capSyncPipe #(
   parameter int  readStages = 2,
   parameter type payloadT   = logic [7:0]
) (
   input  logic    clk,
   input  logic    rstN,
   input  payloadT dataIn,
   output payloadT dataOut
);

   generate
      if (readStages == 0) begin : gPass

         // No latency, output follows input in the same cycle
         assign dataOut = dataIn;

      end else begin : gPipe

         // Stage 0 takes the input, last stage drives the output
         payloadT stageQ [readStages];

         always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
               // Clear every stage so no stale valid escapes after reset
               for (int i = 0; i < readStages; i++) begin
                  stageQ[i] <= '0;
               end
            end else begin
               stageQ[0] <= dataIn;
               // Shift toward the output end
               for (int i = 1; i < readStages; i++) begin
                  stageQ[i] <= stageQ[i-1];
               end
            end
         end

         assign dataOut = stageQ[readStages-1];

      end
   endgenerate

endmodule

//--- src.f
capMemPkg.sv
capSyncPipe.sv
capAccessDecode.sv
capMemArray.sv
capRespRoute.sv
capMemTop.sv
tbCapMem.sv

//--- tbCapMem.sv
// Testbench for the memory wrapper: clock, reset, LFSR stimulus,
// memory reference model, value check and timeout

`timescale 1ns/100ps

module tbCapMem;

   localparam int readStages    = 2;
   // Strobe to response, in cycles
   localparam int rdLat         = 1 + readStages;
   localparam int randCycles    = 2500;
   localparam int timeoutCycles = 4000;

   logic        clk;
   logic        rstN;
   logic        dpRd;
   logic        dpWr;
   logic [7:0]  dpAddr;
   logic [31:0] dpWrData;
   logic        dpRdValid;
   logic [31:0] dpRdData;
   logic        cpuReq;
   logic        cpuWrite;
   logic [7:0]  cpuAddr;
   logic [31:0] cpuWrData;
   logic        cpuBusy;
   logic        cpuAck;
   logic [31:0] cpuRdData;

   // Reference model state
   logic [31:0] modelMem [int];
   int          dueQ [$];
   logic [31:0] dataQ [$];
   logic        pendValid;
   logic        pendWrite;
   logic [7:0]  pendAddr;
   logic [31:0] pendData;
   int          ackDue;
   logic        ackIsRead;
   logic [31:0] ackData;
   logic        busyExp;
   // Cycle in which the DUT last raised cpuAck
   int          ackCyc;
   int          cyc;
   int          wdCnt;
   logic [31:0] lastDpData;
   logic [31:0] lastCpuData;
   logic [31:0] lfsrState;

   capMemTop #(.readStages(readStages)) UUT (
      .clk(clk), .rstN(rstN),
      .dpRd(dpRd), .dpWr(dpWr), .dpAddr(dpAddr), .dpWrData(dpWrData),
      .dpRdValid(dpRdValid), .dpRdData(dpRdData),
      .cpuReq(cpuReq), .cpuWrite(cpuWrite), .cpuAddr(cpuAddr),
      .cpuWrData(cpuWrData), .cpuBusy(cpuBusy), .cpuAck(cpuAck),
      .cpuRdData(cpuRdData)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[30:0], lfsrState[0]};
         lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
      end
      return val;
   endfunction

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
         $display("Some tests failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // One clock cycle: drive, model the array op, then check at the falling edge
   task automatic runCycle(input logic rd, input logic wr, input logic [7:0] addr,
                           input logic [31:0] wdata, input logic req, input logic reqWr,
                           input logic [7:0] reqAddr, input logic [31:0] reqData);
      @(posedge clk);
      #2;
      dpRd      = rd;
      dpWr      = wr;
      dpAddr    = addr;
      dpWrData  = wdata;
      cpuReq    = req;
      cpuWrite  = reqWr;
      cpuAddr   = reqAddr;
      cpuWrData = reqData;
      #8;
      if (req) begin
         pendValid = 1'b1;
         pendWrite = reqWr;
         pendAddr  = reqAddr;
         pendData  = reqData;
      end
      // Datapath first, CPU only in an idle cycle
      if (rd || wr) begin
         if (wr) begin
            modelMem[int'(addr)] = wdata;
         end else begin
            dueQ.push_back(cyc + rdLat);
            dataQ.push_back(modelMem[int'(addr)]);
         end
      end else if (pendValid) begin
         ackDue    = cyc + rdLat;
         ackIsRead = !pendWrite;
         ackData   = modelMem[int'(pendAddr)];
         if (pendWrite) begin
            modelMem[int'(pendAddr)] = pendData;
         end
         pendValid = 1'b0;
      end
      if (cpuAck === 1'b1) begin
         ackCyc = cyc;
      end
      checkEq("cpuBusy", 32'(cpuBusy), 32'(busyExp));
      if (dueQ.size() > 0 && dueQ[0] == cyc) begin
         checkEq("dpRdValid", 32'(dpRdValid), 32'd1);
         checkEq("dpRdData", dpRdData, dataQ[0]);
         lastDpData = dpRdData;
         void'(dueQ.pop_front());
         void'(dataQ.pop_front());
      end else begin
         checkEq("dpRdValid", 32'(dpRdValid), 32'd0);
      end
      if (cyc == ackDue) begin
         checkEq("cpuAck", 32'(cpuAck), 32'd1);
         // Write data on the ack is a don't care
         if (ackIsRead) begin
            checkEq("cpuRdData", cpuRdData, ackData);
         end
         lastCpuData = cpuRdData;
      end else begin
         checkEq("cpuAck", 32'(cpuAck), 32'd0);
      end
      // Busy as seen in the next cycle
      if (req) begin
         busyExp = 1'b1;
      end else if (cyc == ackDue) begin
         busyExp = 1'b0;
      end
      cyc++;
   endtask

   task automatic idleCycle();
      runCycle(1'b0, 1'b0, 8'h00, 32'h0, 1'b0, 1'b0, 8'h00, 32'h0);
   endtask

   task automatic waitCpuDone();
      while (busyExp || pendValid) begin
         idleCycle();
      end
   endtask

   ////////////////////
   // Watchdog
   ////////////////////

   initial begin
      wdCnt = 0;
      while (wdCnt < timeoutCycles) begin
         @(posedge clk);
         wdCnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("Some tests failed");
      $fatal(1, "timeout");
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      logic        strobe;
      logic        wr;
      logic        want;
      logic [31:0] r;
      logic [7:0]  a;
      logic [31:0] d;
      logic        cw;
      logic [7:0]  ca;
      logic [31:0] cd;
      int          burstEnd;

      rstN = 1'b0;
      dpRd = 1'b0;
      dpWr = 1'b0;
      dpAddr = '0;
      dpWrData = '0;
      cpuReq = 1'b0;
      cpuWrite = 1'b0;
      cpuAddr = '0;
      cpuWrData = '0;
      lfsrState = 32'hfa47;
      pendValid = 1'b0;
      pendWrite = 1'b0;
      pendAddr = '0;
      pendData = '0;
      ackDue = -1;
      ackIsRead = 1'b0;
      ackData = '0;
      busyExp = 1'b0;
      ackCyc = -1;
      cyc = 0;
      lastDpData = '0;
      lastCpuData = '0;

      // Outputs quiet during reset and right after release
      repeat (10) begin
         @(posedge clk);
         #10;
         checkEq("dpRdValid", 32'(dpRdValid), 32'd0);
         checkEq("cpuAck", 32'(cpuAck), 32'd0);
         checkEq("cpuBusy", 32'(cpuBusy), 32'd0);
      end
      @(posedge clk);
      #2;
      rstN = 1'b1;
      #8;
      checkEq("dpRdValid", 32'(dpRdValid), 32'd0);
      checkEq("cpuAck", 32'(cpuAck), 32'd0);
      checkEq("cpuBusy", 32'(cpuBusy), 32'd0);

      // Preload the 16 test addresses so no read returns X
      for (int i = 0; i < 16; i++) begin
         d = randBits(32);
         runCycle(1'b0, 1'b1, 8'(i), d, 1'b0, 1'b0, 8'h00, 32'h0);
      end

      // Mixed random traffic, strobe density 10 of 16
      for (int i = 0; i < randCycles; i++) begin
         r = randBits(4);
         strobe = r[3:0] < 4'd10;
         r = randBits(1);
         wr = r[0];
         r = randBits(4);
         a = {4'h0, r[3:0]};
         d = randBits(32);
         r = randBits(2);
         want = r[1:0] == 2'd0;
         r = randBits(1);
         cw = r[0];
         r = randBits(4);
         ca = {4'h0, r[3:0]};
         cd = randBits(32);
         runCycle(strobe && !wr, strobe && wr, a, d, want && !busyExp, cw, ca, cd);
      end
      waitCpuDone();

      // Burst of 50 strobes with a CPU read held off until the end
      for (int i = 0; i < 50; i++) begin
         r = randBits(1);
         wr = r[0];
         r = randBits(4);
         a = {4'h0, r[3:0]};
         d = randBits(32);
         runCycle(!wr, wr, a, d, i == 0, 1'b0, 8'h05, 32'h0);
      end
      burstEnd = cyc;
      waitCpuDone();
      // Ack due a fixed latency after the first idle cycle
      checkEq("cpuAckCycle", 32'(ackCyc), 32'(burstEnd + rdLat));

      // CPU write then datapath read of the same word
      runCycle(1'b0, 1'b0, 8'h00, 32'h0, 1'b1, 1'b1, 8'h07, 32'hc0de0007);
      waitCpuDone();
      runCycle(1'b1, 1'b0, 8'h07, 32'h0, 1'b0, 1'b0, 8'h00, 32'h0);
      while (dueQ.size() > 0) begin
         idleCycle();
      end
      checkEq("dpRdData", lastDpData, 32'hc0de0007);

      // Datapath write then CPU read of the same word
      runCycle(1'b0, 1'b1, 8'h0b, 32'h5a5a000b, 1'b0, 1'b0, 8'h00, 32'h0);
      runCycle(1'b0, 1'b0, 8'h00, 32'h0, 1'b1, 1'b0, 8'h0b, 32'h0);
      waitCpuDone();
      checkEq("cpuRdData", lastCpuData, 32'h5a5a000b);

      // Drain and make sure nothing stray follows
      repeat (rdLat + 2) begin
         idleCycle();
      end
      $display("All tests passed");
      $finish;
   end

endmodule
